//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// reset vector low byte, high byte follows
`define CPU_RST_VECTOR  16'hfffc
`define CPU_ZERO_PAGE   8'h00       // high address byte of zero-page operands

// loads
`define CPU_OP_LDA_IMM  8'ha9
`define CPU_OP_LDA_ZPG  8'ha5
`define CPU_OP_LDA_ABS  8'had
`define CPU_OP_LDX_IMM  8'ha2
`define CPU_OP_LDX_ZPG  8'ha6
`define CPU_OP_LDX_ABS  8'hae
`define CPU_OP_LDY_IMM  8'ha0
`define CPU_OP_LDY_ZPG  8'ha4
`define CPU_OP_LDY_ABS  8'hac

// stores
`define CPU_OP_STA_ZPG  8'h85
`define CPU_OP_STA_ABS  8'h8d
`define CPU_OP_STX_ZPG  8'h86
`define CPU_OP_STX_ABS  8'h8e
`define CPU_OP_STY_ZPG  8'h84
`define CPU_OP_STY_ABS  8'h8c

// accumulator alu group
`define CPU_OP_ORA_IMM  8'h09
`define CPU_OP_ORA_ZPG  8'h05
`define CPU_OP_ORA_ABS  8'h0d
`define CPU_OP_AND_IMM  8'h29
`define CPU_OP_AND_ZPG  8'h25
`define CPU_OP_AND_ABS  8'h2d
`define CPU_OP_EOR_IMM  8'h49
`define CPU_OP_EOR_ZPG  8'h45
`define CPU_OP_EOR_ABS  8'h4d
`define CPU_OP_ADC_IMM  8'h69
`define CPU_OP_ADC_ZPG  8'h65
`define CPU_OP_ADC_ABS  8'h6d
`define CPU_OP_CMP_IMM  8'hc9
`define CPU_OP_CMP_ZPG  8'hc5
`define CPU_OP_CMP_ABS  8'hcd
`define CPU_OP_SBC_IMM  8'he9
`define CPU_OP_SBC_ZPG  8'he5
`define CPU_OP_SBC_ABS  8'hed

// implied
`define CPU_OP_TAX      8'haa
`define CPU_OP_TAY      8'ha8
`define CPU_OP_TXA      8'h8a
`define CPU_OP_TYA      8'h98
`define CPU_OP_INX      8'he8
`define CPU_OP_INY      8'hc8
`define CPU_OP_DEX      8'hca
`define CPU_OP_DEY      8'h88
`define CPU_OP_CLC      8'h18
`define CPU_OP_SEC      8'h38
`define CPU_OP_NOP      8'hea

`define CPU_OP_JMP_ABS  8'h4c

`endif

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  byte_t;    // data bus and register width
    typedef logic [15:0] addr_t;

    // bus cycle sequencer states
    typedef enum logic [2:0] {
        st_boot_lo,     // reset vector low byte
        st_boot_hi,
        st_fetch,       // opcode on the bus, sync high
        st_decode,      // first byte after the opcode
        st_zpg,
        st_abs_hi,
        st_abs_mem,
        st_jam
    } cpu_state_t;

    // subtract is add with the second operand inverted
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_or,
        alu_eor
    } alu_op_t;

    typedef enum logic [1:0] {
        reg_none,
        reg_a,
        reg_x,
        reg_y
    } reg_sel_t;

    typedef enum logic [1:0] {
        res_data,       // straight from the bus
        res_alu,
        res_reg         // source register, for transfers
    } res_src_t;

    typedef enum logic [2:0] {
        mode_imp,
        mode_imm,
        mode_zpg,
        mode_abs,
        mode_jmp
    } mode_t;

endpackage

//--- cpu_alu.sv
module cpu_alu (
    input  cpu_pkg::byte_t   i_a,
    input  cpu_pkg::byte_t   i_b,
    input  logic             i_cin,
    input  cpu_pkg::alu_op_t i_op,
    output cpu_pkg::byte_t   o_res,
    output logic             o_cout
);
    import cpu_pkg::*;

    logic [8:0] sum;    // bit 8 is the carry out

    assign sum = {1'b0, i_a} + {1'b0, i_b} + {8'h00, i_cin};

    always_comb begin
        o_res  = sum[7:0];
        o_cout = i_cin;     // logic ops leave the carry as it came in
        case (i_op)
            alu_add: o_cout = sum[8];
            alu_and: o_res = i_a & i_b;
            alu_or:  o_res = i_a | i_b;
            alu_eor: o_res = i_a ^ i_b;
        endcase
    end

endmodule

//--- cpu_decode.sv
`include "cpu_consts.svh"

module cpu_decode (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::byte_t      i_data,
    input  logic                i_ir_load,
    output cpu_pkg::mode_t      o_mode,
    output logic                o_is_store,
    output logic                o_illegal,
    output cpu_pkg::reg_sel_t   o_src_reg,
    output cpu_pkg::reg_sel_t   o_dst_reg,
    output cpu_pkg::res_src_t   o_res_src,
    output cpu_pkg::alu_op_t    o_alu_op,
    output logic                o_b_inv,
    output logic                o_cin_sel,      // high picks the carry flag
    output logic                o_cin_const,
    output logic                o_carry_we
);
    import cpu_pkg::*;

    byte_t ir;
    byte_t opcode;

    // operand mode from the bbb field of a load, store or alu opcode
    function automatic mode_t mem_mode(input byte_t op);
        case (op[4:2])
            3'b001:  return mode_zpg;
            3'b011:  return mode_abs;
            default: return mode_imm;
        endcase
    endfunction

    // register named by the cc field of a load or store
    function automatic reg_sel_t ld_st_reg(input byte_t op);
        case (op[1:0])
            2'b01:   return reg_a;
            2'b10:   return reg_x;
            default: return reg_y;
        endcase
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst)
            ir <= `CPU_OP_JMP_ABS;
        else if (i_ir_load)
            ir <= i_data;
    end

    // opcode is live on the bus during the fetch cycle
    assign opcode = i_ir_load ? i_data : ir;

    always_comb begin
        o_mode      = mode_imp;
        o_is_store  = 1'b0;
        o_illegal   = 1'b0;
        o_src_reg   = reg_none;
        o_dst_reg   = reg_none;
        o_res_src   = res_data;
        o_alu_op    = alu_add;
        o_b_inv     = 1'b0;
        o_cin_sel   = 1'b0;
        o_cin_const = 1'b0;
        o_carry_we  = 1'b0;
        case (opcode)
            `CPU_OP_LDA_IMM, `CPU_OP_LDA_ZPG, `CPU_OP_LDA_ABS,
            `CPU_OP_LDX_IMM, `CPU_OP_LDX_ZPG, `CPU_OP_LDX_ABS,
            `CPU_OP_LDY_IMM, `CPU_OP_LDY_ZPG, `CPU_OP_LDY_ABS: begin
                o_mode    = mem_mode(opcode);
                o_dst_reg = ld_st_reg(opcode);
            end
            `CPU_OP_STA_ZPG, `CPU_OP_STA_ABS, `CPU_OP_STX_ZPG,
            `CPU_OP_STX_ABS, `CPU_OP_STY_ZPG, `CPU_OP_STY_ABS: begin
                o_mode     = mem_mode(opcode);
                o_is_store = 1'b1;
                o_src_reg  = ld_st_reg(opcode);
            end
            `CPU_OP_ORA_IMM, `CPU_OP_ORA_ZPG, `CPU_OP_ORA_ABS,
            `CPU_OP_AND_IMM, `CPU_OP_AND_ZPG, `CPU_OP_AND_ABS,
            `CPU_OP_EOR_IMM, `CPU_OP_EOR_ZPG, `CPU_OP_EOR_ABS,
            `CPU_OP_ADC_IMM, `CPU_OP_ADC_ZPG, `CPU_OP_ADC_ABS,
            `CPU_OP_CMP_IMM, `CPU_OP_CMP_ZPG, `CPU_OP_CMP_ABS,
            `CPU_OP_SBC_IMM, `CPU_OP_SBC_ZPG, `CPU_OP_SBC_ABS: begin
                o_mode    = mem_mode(opcode);
                o_src_reg = reg_a;
                o_dst_reg = reg_a;
                o_res_src = res_alu;
                case (opcode[7:5])     // aaa field picks the operation
                    3'b000: o_alu_op = alu_or;
                    3'b001: o_alu_op = alu_and;
                    3'b010: o_alu_op = alu_eor;
                    3'b011: begin      // adc
                        o_cin_sel  = 1'b1;
                        o_carry_we = 1'b1;
                    end
                    3'b110: begin      // cmp, a - m with only the carry kept
                        o_dst_reg   = reg_none;
                        o_b_inv     = 1'b1;
                        o_cin_const = 1'b1;
                        o_carry_we  = 1'b1;
                    end
                    default: begin     // sbc
                        o_b_inv    = 1'b1;
                        o_cin_sel  = 1'b1;
                        o_carry_we = 1'b1;
                    end
                endcase
            end
            `CPU_OP_TAX: begin
                o_src_reg = reg_a;
                o_dst_reg = reg_x;
                o_res_src = res_reg;
            end
            `CPU_OP_TAY: begin
                o_src_reg = reg_a;
                o_dst_reg = reg_y;
                o_res_src = res_reg;
            end
            `CPU_OP_TXA: begin
                o_src_reg = reg_x;
                o_dst_reg = reg_a;
                o_res_src = res_reg;
            end
            `CPU_OP_TYA: begin
                o_src_reg = reg_y;
                o_dst_reg = reg_a;
                o_res_src = res_reg;
            end
            `CPU_OP_INX, `CPU_OP_INY: begin
                o_src_reg   = (opcode == `CPU_OP_INX) ? reg_x : reg_y;
                o_dst_reg   = o_src_reg;
                o_res_src   = res_alu;
                o_cin_const = 1'b1;    // r + 0 + 1
            end
            `CPU_OP_DEX, `CPU_OP_DEY: begin
                o_src_reg = (opcode == `CPU_OP_DEX) ? reg_x : reg_y;
                o_dst_reg = o_src_reg;
                o_res_src = res_alu;
                o_b_inv   = 1'b1;      // r + ff
            end
            `CPU_OP_CLC, `CPU_OP_SEC: begin
                o_alu_op    = alu_and;  // carry passes straight through
                o_cin_const = (opcode == `CPU_OP_SEC);
                o_carry_we  = 1'b1;
            end
            `CPU_OP_JMP_ABS: o_mode = mode_jmp;
            `CPU_OP_NOP: begin
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

//--- cpu_sequencer.sv
`include "cpu_consts.svh"

module cpu_sequencer (
    input  logic            i_clk,
    input  logic            i_rst,
    input  cpu_pkg::byte_t  i_data,
    input  cpu_pkg::mode_t  i_mode,
    input  logic            i_is_store,
    input  logic            i_illegal,
    output cpu_pkg::addr_t  o_addr,
    output logic            o_rw,
    output logic            o_sync,
    output logic            o_jam,
    output logic            o_ir_load,
    output logic            o_exec,
    output logic            o_store
);
    import cpu_pkg::*;

    cpu_state_t state;
    cpu_state_t state_nxt;
    addr_t      pc;
    byte_t      op_lo;      // first operand byte, also vector low byte
    byte_t      op_hi;
    logic       mem_cycle;  // data cycle of a zpg or abs instruction
    logic       pc_inc;
    logic       pc_load;

    assign mem_cycle = (state == st_zpg) || (state == st_abs_mem);

    always_comb begin
        state_nxt = state;
        case (state)
            st_boot_lo: state_nxt = st_boot_hi;
            st_boot_hi: state_nxt = st_fetch;
            st_fetch:   state_nxt = i_illegal ? st_jam : st_decode;
            st_decode: begin
                case (i_mode)
                    mode_zpg:           state_nxt = st_zpg;
                    mode_abs, mode_jmp: state_nxt = st_abs_hi;
                    default:            state_nxt = st_fetch;
                endcase
            end
            st_abs_hi:  state_nxt = (i_mode == mode_jmp) ? st_fetch : st_abs_mem;
            st_zpg:     state_nxt = st_fetch;
            st_abs_mem: state_nxt = st_fetch;
            default:    state_nxt = st_jam;     // stuck until reset
        endcase
    end

    always_comb begin
        case (state)
            st_boot_lo: o_addr = `CPU_RST_VECTOR;
            st_boot_hi: o_addr = `CPU_RST_VECTOR + 16'd1;
            st_zpg:     o_addr = {`CPU_ZERO_PAGE, op_lo};
            st_abs_mem: o_addr = {op_hi, op_lo};
            default:    o_addr = pc;
        endcase
    end

    // implied ops only peek at the next byte
    assign pc_inc = (state == st_fetch) ||
                    (state == st_decode && i_mode != mode_imp) ||
                    (state == st_abs_hi && i_mode == mode_abs);
    assign pc_load = (state == st_boot_hi) ||
                     (state == st_abs_hi && i_mode == mode_jmp);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= st_boot_lo;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            if (pc_load)
                pc <= {i_data, op_lo};
            else if (pc_inc)
                pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == st_boot_lo || state == st_decode)
            op_lo <= i_data;
        if (state == st_abs_hi)
            op_hi <= i_data;
    end

    assign o_sync    = (state == st_fetch);
    assign o_ir_load = (state == st_fetch);     // opcode arrives in the same cycle
    assign o_jam     = (state == st_jam);
    assign o_store   = mem_cycle && i_is_store;
    assign o_rw      = !o_store;

    // immediate and implied execute while the operand byte is on the bus
    assign o_exec = (mem_cycle && !i_is_store) ||
                    (state == st_decode && (i_mode == mode_imm || i_mode == mode_imp));

endmodule

//--- cpu_datapath.sv
module cpu_datapath (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::byte_t      i_data,
    input  logic                i_exec,
    input  logic                i_store,
    input  cpu_pkg::reg_sel_t   i_src_reg,
    input  cpu_pkg::reg_sel_t   i_dst_reg,
    input  cpu_pkg::res_src_t   i_res_src,
    input  cpu_pkg::alu_op_t    i_alu_op,
    input  logic                i_b_inv,
    input  logic                i_cin_sel,
    input  logic                i_cin_const,
    input  logic                i_carry_we,
    output cpu_pkg::byte_t      o_dor
);
    import cpu_pkg::*;

    byte_t    a;
    byte_t    x;
    byte_t    y;
    logic     carry;
    byte_t    src_val;
    byte_t    alu_b;
    logic     alu_cin;
    byte_t    alu_res;
    logic     alu_cout;
    byte_t    result;
    reg_sel_t pend_dst;     // lands one cycle after exec
    byte_t    pend_res;
    logic     pend_cwe;
    logic     pend_c;

    always_comb begin
        case (i_src_reg)
            reg_a:   src_val = a;
            reg_x:   src_val = x;
            reg_y:   src_val = y;
            default: src_val = '0;
        endcase
    end

    // memory operand only meets the accumulator, index counting adds zero
    assign alu_b   = ((i_src_reg == reg_a) ? i_data : 8'h00) ^ {8{i_b_inv}};
    assign alu_cin = i_cin_sel ? carry : i_cin_const;

    cpu_alu u_alu (
        .i_a    (src_val),
        .i_b    (alu_b),
        .i_cin  (alu_cin),
        .i_op   (i_alu_op),
        .o_res  (alu_res),
        .o_cout (alu_cout)
    );

    always_comb begin
        case (i_res_src)
            res_alu: result = alu_res;
            res_reg: result = src_val;
            default: result = i_data;   // loads
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pend_dst <= reg_none;
            pend_cwe <= 1'b0;
        end else begin
            pend_dst <= i_exec ? i_dst_reg : reg_none;
            pend_cwe <= i_exec && i_carry_we;
        end
    end

    always_ff @(posedge i_clk) begin
        pend_res <= result;
        pend_c   <= alu_cout;
    end

    // write back during the next opcode fetch
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a     <= '0;
            x     <= '0;
            y     <= '0;
            carry <= 1'b0;
        end else begin
            case (pend_dst)
                reg_a:   a <= pend_res;
                reg_x:   x <= pend_res;
                reg_y:   y <= pend_res;
                default: begin
                end
            endcase
            if (pend_cwe)
                carry <= pend_c;
        end
    end

    assign o_dor = i_store ? src_val : 8'h00;

endmodule

//--- cpu_top.sv
module cpu_top (
    input  logic            i_clk,
    input  logic            i_rst,
    input  cpu_pkg::byte_t  i_data,
    output cpu_pkg::addr_t  o_addr,
    output cpu_pkg::byte_t  o_dor,
    output logic            o_rw,
    output logic            o_sync,
    output logic            o_jam
);
    import cpu_pkg::*;

    mode_t    mode;
    logic     is_store;
    logic     illegal;
    logic     ir_load;
    logic     exec;
    logic     store;
    reg_sel_t src_reg;
    reg_sel_t dst_reg;
    res_src_t res_src;
    alu_op_t  alu_op;
    logic     b_inv;
    logic     cin_sel;
    logic     cin_const;
    logic     carry_we;

    cpu_sequencer u_seq (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_data     (i_data),
        .i_mode     (mode),
        .i_is_store (is_store),
        .i_illegal  (illegal),
        .o_addr     (o_addr),
        .o_rw       (o_rw),
        .o_sync     (o_sync),
        .o_jam      (o_jam),
        .o_ir_load  (ir_load),
        .o_exec     (exec),
        .o_store    (store)
    );

    cpu_decode u_dec (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_data      (i_data),
        .i_ir_load   (ir_load),
        .o_mode      (mode),
        .o_is_store  (is_store),
        .o_illegal   (illegal),
        .o_src_reg   (src_reg),
        .o_dst_reg   (dst_reg),
        .o_res_src   (res_src),
        .o_alu_op    (alu_op),
        .o_b_inv     (b_inv),
        .o_cin_sel   (cin_sel),
        .o_cin_const (cin_const),
        .o_carry_we  (carry_we)
    );

    cpu_datapath u_dp (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_data      (i_data),
        .i_exec      (exec),
        .i_store     (store),
        .i_src_reg   (src_reg),
        .i_dst_reg   (dst_reg),
        .i_res_src   (res_src),
        .i_alu_op    (alu_op),
        .i_b_inv     (b_inv),
        .i_cin_sel   (cin_sel),
        .i_cin_const (cin_const),
        .i_carry_we  (carry_we),
        .o_dor       (o_dor)
    );

endmodule

//--- cpu_chk.sv
module cpu_chk (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_rw,
    input  logic            i_sync,
    input  logic            i_jam,
    input  cpu_pkg::byte_t  i_dor
);
    import cpu_pkg::*;

    int fail_count = 0;     // failed assertions so far

    // opcode fetch is always a read
    a_sync_read: assert property (@(posedge i_clk) disable iff (i_rst) i_sync |-> i_rw)
        else begin
            fail_count++;
            $error("sync strobe in a write cycle");
        end

    a_dor_idle: assert property (@(posedge i_clk) disable iff (i_rst) i_rw |-> (i_dor == 8'h00))
        else begin
            fail_count++;
            $error("write data not zero during a read");
        end

    // only reset leaves the jam state
    a_jam_hold: assert property (@(posedge i_clk) disable iff (i_rst) i_jam |=> i_jam)
        else begin
            fail_count++;
            $error("jam dropped without reset");
        end

endmodule

bind cpu_top cpu_chk u_chk (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_rw   (o_rw),
    .i_sync (o_sync),
    .i_jam  (o_jam),
    .i_dor  (o_dor)
);

//--- tb_cpu.sv
`include "cpu_consts.svh"

module tb_cpu;
    import cpu_pkg::*;

    // per operand pair five ops of at most 20 cycles and a 14 cycle compare
    localparam int arith_cycles = 20 * (5 * 20 + 14);
    localparam int reset_cycles = 6 * 14;
    localparam int other_cycles = 400;      // the five short tests together
    localparam int cycle_limit  = arith_cycles + reset_cycles + other_cycles + 500;

    logic  clk;
    logic  rst;
    byte_t bus_data;
    addr_t bus_addr;
    byte_t dor;
    logic  rw;
    logic  sync;
    logic  jam;

    byte_t       mem [0:65535];
    int          cycles;
    int          since_rst;
    int          sync_cyc[$];
    addr_t       sync_addr[$];
    addr_t       wr_addr[$];
    byte_t       wr_data[$];
    addr_t       exp_addr[$];
    byte_t       exp_data[$];
    addr_t       fetch_pc[$];       // expected opcode addresses
    int          fetch_len[$];
    addr_t       pc_w;              // assembly pointer
    int          slot;              // next free operand location
    int unsigned lcg_state = 71588;

    cpu_top uut (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_data (bus_data),
        .o_addr (bus_addr),
        .o_dor  (dor),
        .o_rw   (rw),
        .o_sync (sync),
        .o_jam  (jam)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign bus_data = $isunknown(bus_addr) ? 8'h00 : mem[bus_addr];    // combinational read

    // memory writes, logs of writes and fetches, run limit and assertion watch
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst)
            since_rst <= 0;
        else
            since_rst <= since_rst + 1;
        if (sync === 1'b1) begin
            sync_cyc.push_back(since_rst + 1);     // cycle number counted from reset release
            sync_addr.push_back(bus_addr);
        end
        if (rw === 1'b0) begin
            mem[bus_addr] <= dor;
            wr_addr.push_back(bus_addr);
            wr_data.push_back(dor);
        end
        if (cycles > cycle_limit)
            fail_run($sformatf("timeout: run passed the limit of %0d cycles", cycle_limit));
        else if (uut.u_chk.fail_count != 0)
            fail_run($sformatf("%0d bound assertion failures", uut.u_chk.fail_count));
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    function byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // mode 0 immediate, 1 zero page, 2 absolute
    function automatic byte_t pick_mode(input int mode, input byte_t imm, input byte_t zpg,
                                        input byte_t abs_op);
        case (mode)
            0:       return imm;
            1:       return zpg;
            default: return abs_op;
        endcase
    endfunction

    // register 0 is A, 1 is X, 2 is Y
    function automatic byte_t ld_opcode(input int r, input int mode);
        case (r)
            0:       return pick_mode(mode, `CPU_OP_LDA_IMM, `CPU_OP_LDA_ZPG, `CPU_OP_LDA_ABS);
            1:       return pick_mode(mode, `CPU_OP_LDX_IMM, `CPU_OP_LDX_ZPG, `CPU_OP_LDX_ABS);
            default: return pick_mode(mode, `CPU_OP_LDY_IMM, `CPU_OP_LDY_ZPG, `CPU_OP_LDY_ABS);
        endcase
    endfunction

    // op order is ORA, AND, EOR, ADC, SBC, CMP
    function automatic byte_t alu_opcode(input int op, input int mode);
        case (op)
            0:       return pick_mode(mode, `CPU_OP_ORA_IMM, `CPU_OP_ORA_ZPG, `CPU_OP_ORA_ABS);
            1:       return pick_mode(mode, `CPU_OP_AND_IMM, `CPU_OP_AND_ZPG, `CPU_OP_AND_ABS);
            2:       return pick_mode(mode, `CPU_OP_EOR_IMM, `CPU_OP_EOR_ZPG, `CPU_OP_EOR_ABS);
            3:       return pick_mode(mode, `CPU_OP_ADC_IMM, `CPU_OP_ADC_ZPG, `CPU_OP_ADC_ABS);
            4:       return pick_mode(mode, `CPU_OP_SBC_IMM, `CPU_OP_SBC_ZPG, `CPU_OP_SBC_ABS);
            default: return pick_mode(mode, `CPU_OP_CMP_IMM, `CPU_OP_CMP_ZPG, `CPU_OP_CMP_ABS);
        endcase
    endfunction

    // binary-mode 6502 result with the carry in bit 8
    function automatic logic [8:0] ref_alu(input int op, input byte_t a, input byte_t m,
                                           input logic c);
        int r;
        case (op)
            0: return {c, a | m};
            1: return {c, a & m};
            2: return {c, a ^ m};
            3: begin
                r = int'(a) + int'(m) + int'(c);
                return {r > 255, r[7:0]};
            end
            4: begin
                r = int'(a) - int'(m) - (c ? 0 : 1);   // borrow is the inverted carry
                return {r >= 0, r[7:0]};
            end
            default: return {a >= m, a};
        endcase
    endfunction

    task automatic emit(input byte_t b);
        mem[pc_w] = b;
        pc_w = pc_w + 16'd1;
    endtask

    task automatic emit_imm(input byte_t op, input byte_t v);
        emit(op);
        emit(v);
    endtask

    task automatic emit_abs(input byte_t op, input addr_t a);
        emit(op);
        emit(a[7:0]);
        emit(a[15:8]);
    endtask

    // places the operand value where the mode will read it
    task automatic emit_operand(input byte_t op, input int mode, input byte_t v);
        addr_t loc;
        case (mode)
            0: emit_imm(op, v);
            1: begin
                loc = 16'h0040 + addr_t'(slot);
                mem[loc] = v;
                emit_imm(op, loc[7:0]);
            end
            default: begin
                loc = 16'h3000 + addr_t'(slot);
                mem[loc] = v;
                emit_abs(op, loc);
            end
        endcase
        slot++;
    endtask

    task automatic store_reg(input int r, input logic zpg, input byte_t val);
        addr_t dst;
        if (zpg) begin
            dst = 16'h0010 + addr_t'(exp_addr.size());
            emit_imm(r == 0 ? `CPU_OP_STA_ZPG : r == 1 ? `CPU_OP_STX_ZPG : `CPU_OP_STY_ZPG,
                     dst[7:0]);
        end else begin
            dst = 16'h4000 + addr_t'(exp_addr.size());
            emit_abs(r == 0 ? `CPU_OP_STA_ABS : r == 1 ? `CPU_OP_STX_ABS : `CPU_OP_STY_ABS, dst);
        end
        exp_addr.push_back(dst);
        exp_data.push_back(val);
    endtask

    // carry lands in bit 0 of a stored byte
    task automatic save_carry(input logic c);
        emit_imm(`CPU_OP_LDA_IMM, 8'h00);
        emit_imm(`CPU_OP_ADC_IMM, 8'h00);
        store_reg(0, 1'b0, {7'd0, c});
    endtask

    task automatic mark(input int len);
        fetch_pc.push_back(pc_w);
        fetch_len.push_back(len);
    endtask

    task automatic finish_prog(output addr_t stop);
        stop = pc_w;
        emit_abs(`CPU_OP_JMP_ABS, pc_w);  // jump to itself
    endtask

    task automatic load_image(input addr_t vec);
        for (int i = 0; i < 65536; i++)
            mem[i] = byte_t'(i[15:8] ^ i[7:0] ^ 8'h5a);
        mem[`CPU_RST_VECTOR]     = vec[7:0];
        mem[`CPU_RST_VECTOR + 1] = vec[15:8];
        pc_w = vec;
        slot = 0;
        exp_addr.delete();
        exp_data.delete();
        fetch_pc.delete();
        fetch_len.delete();
    endtask

    task automatic assert_reset();
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);     // reset has taken hold
    endtask

    task automatic release_reset();
        repeat (9) begin
            @(negedge clk);
            check_bit("sync in reset", sync, 1'b0);
            check_bit("jam in reset", jam, 1'b0);
            check_bit("rw in reset", rw, 1'b1);
        end
        sync_cyc.delete();
        sync_addr.delete();
        wr_addr.delete();
        wr_data.delete();
        @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_fetch(input addr_t stop);
        do
            @(negedge clk);
        while (!(sync === 1'b1 && bus_addr === stop));
    endtask

    task automatic run_until(input addr_t stop);
        wait_fetch(stop);
        @(negedge clk);     // logs now hold the final fetch
    endtask

    task automatic check_writes(input string name);
        if (wr_addr.size() != exp_addr.size())
            fail_run($sformatf("%s: %0d writes seen, %0d expected", name, wr_addr.size(),
                               exp_addr.size()));
        foreach (exp_addr[i]) begin
            check_addr($sformatf("%s write %0d address", name, i), wr_addr[i], exp_addr[i]);
            check_byte($sformatf("%s write %0d data", name, i), wr_data[i], exp_data[i]);
        end
    endtask

    task automatic test_boot();
        addr_t stop;
        assert_reset();
        load_image(16'h8421);
        store_reg(0, 1'b1, 8'h00);
        store_reg(1, 1'b1, 8'h00);
        store_reg(2, 1'b1, 8'h00);
        save_carry(1'b0);   // carry clear out of reset
        finish_prog(stop);
        release_reset();
        @(negedge clk);
        check_addr("vector low read", bus_addr, `CPU_RST_VECTOR);
        check_bit("sync in boot", sync, 1'b0);
        @(negedge clk);
        check_addr("vector high read", bus_addr, `CPU_RST_VECTOR + 16'd1);
        check_bit("sync in boot", sync, 1'b0);
        @(negedge clk);
        check_bit("first fetch sync", sync, 1'b1);
        check_addr("first fetch address", bus_addr, 16'h8421);
        run_until(stop);
        check_byte("first sync cycle", byte_t'(sync_cyc[0]), 8'd3);
        check_writes("reset state");
    endtask

    task automatic test_load_store();
        addr_t stop;
        byte_t v;
        assert_reset();
        load_image(16'h0200);
        for (int i = 0; i < 9; i++) begin
            v = lcg_byte();
            emit_operand(ld_opcode(i % 3, i / 3), i / 3, v);
            store_reg(i % 3, (i % 2) == 0, v);
        end
        finish_prog(stop);
        release_reset();
        run_until(stop);
        check_writes("loads and stores");
    endtask

    task automatic test_arith();
        addr_t      stop;
        byte_t      a;
        byte_t      m;
        byte_t      v;
        logic [8:0] r;
        int         mode;
        assert_reset();
        load_image(16'h0200);
        for (int k = 0; k < 20; k++) begin
            a = lcg_byte();
            m = lcg_byte();
            for (int op = 0; op < 5; op++) begin
                v = lcg_byte();
                mode = (k + op) % 3;
                emit(v[7] ? `CPU_OP_SEC : `CPU_OP_CLC);
                emit_imm(`CPU_OP_LDA_IMM, a);
                emit_operand(alu_opcode(op, mode), mode, m);
                r = ref_alu(op, a, m, v[7]);
                store_reg(0, 1'b0, r[7:0]);
                save_carry(r[8]);
            end
            emit_imm(`CPU_OP_LDA_IMM, a);
            emit_operand(alu_opcode(5, k % 3), k % 3, m);
            r = ref_alu(5, a, m, 1'b0);
            save_carry(r[8]);
        end
        finish_prog(stop);
        release_reset();
        run_until(stop);
        check_writes("arithmetic");
    endtask

    task automatic test_count();
        addr_t stop;
        byte_t ra;
        byte_t rx;
        byte_t ry;
        assert_reset();
        load_image(16'h0200);
        ra = lcg_byte();
        emit_imm(`CPU_OP_LDA_IMM, ra);
        emit(`CPU_OP_TAX);
        rx = ra;
        store_reg(1, 1'b0, rx);
        emit(`CPU_OP_TAY);
        ry = ra;
        store_reg(2, 1'b1, ry);
        emit_imm(`CPU_OP_LDX_IMM, 8'hfe);
        rx = 8'hfe;
        repeat (3) begin
            emit(`CPU_OP_INX);
            rx = rx + 8'd1;
            store_reg(1, 1'b0, rx);
        end
        repeat (3) begin
            emit(`CPU_OP_DEX);
            rx = rx - 8'd1;
            store_reg(1, 1'b0, rx);
        end
        emit_imm(`CPU_OP_LDY_IMM, 8'h01);
        ry = 8'h01;
        repeat (3) begin
            emit(`CPU_OP_DEY);
            ry = ry - 8'd1;
            store_reg(2, 1'b0, ry);
        end
        repeat (3) begin
            emit(`CPU_OP_INY);
            ry = ry + 8'd1;
            store_reg(2, 1'b0, ry);
        end
        emit(`CPU_OP_TXA);
        store_reg(0, 1'b0, rx);
        emit(`CPU_OP_TYA);
        store_reg(0, 1'b0, ry);
        finish_prog(stop);
        release_reset();
        run_until(stop);
        check_writes("transfers and counting");
    endtask

    task automatic test_timing();
        addr_t stop;
        assert_reset();
        load_image(16'h0300);
        mark(2);
        emit(`CPU_OP_NOP);
        mark(2);
        emit_imm(`CPU_OP_LDA_IMM, 8'h3c);
        mark(3);
        emit_operand(`CPU_OP_LDA_ZPG, 1, 8'h5d);
        mark(3);
        emit_imm(`CPU_OP_STA_ZPG, 8'h20);
        mark(4);
        emit_operand(`CPU_OP_LDX_ABS, 2, 8'h11);
        mark(4);
        emit_abs(`CPU_OP_STX_ABS, 16'h4100);
        mark(2);
        emit_imm(`CPU_OP_ADC_IMM, 8'h01);
        mark(4);
        emit_operand(`CPU_OP_SBC_ABS, 2, 8'h07);
        mark(2);
        emit(`CPU_OP_TAX);
        mark(3);
        emit_abs(`CPU_OP_JMP_ABS, 16'h5a5a);
        pc_w = 16'h5a5a;    // jump target
        mark(3);
        finish_prog(stop);
        release_reset();
        run_until(stop);
        foreach (fetch_pc[i]) begin
            check_addr($sformatf("fetch %0d address", i), sync_addr[i], fetch_pc[i]);
            if (i + 1 < fetch_pc.size())
                check_byte($sformatf("fetch %0d length", i),
                           byte_t'(sync_cyc[i + 1] - sync_cyc[i]), byte_t'(fetch_len[i]));
        end
    endtask

    task automatic test_jam();
        addr_t jam_pc;
        byte_t v;
        assert_reset();
        load_image(16'h0600);
        v = lcg_byte();
        emit_imm(`CPU_OP_LDA_IMM, v);
        store_reg(0, 1'b1, v);
        jam_pc = pc_w;
        emit(8'h02);        // undefined opcode
        release_reset();
        wait_fetch(jam_pc);
        check_bit("jam during fetch", jam, 1'b0);
        @(negedge clk);
        check_bit("jam after fetch", jam, 1'b1);
        repeat (20) begin
            @(negedge clk);
            check_bit("jam held", jam, 1'b1);
            check_bit("sync while jammed", sync, 1'b0);
            check_bit("rw while jammed", rw, 1'b1);
        end
        check_writes("jam");
    endtask

    initial begin
        rst = 1'b1;
        load_image(16'h0000);
        test_boot();
        test_load_store();
        test_arith();
        test_count();
        test_timing();
        test_jam();
        if (uut.u_chk.fail_count != 0) begin
            fail_run($sformatf("%0d bound assertion failures", uut.u_chk.fail_count));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_decode.sv
cpu_sequencer.sv
cpu_datapath.sv
cpu_top.sv
cpu_chk.sv
tb_cpu.sv
